// ==== axis_cfg.svh ====
// stream width loop configuration: lane widths, sideband width and word FIFO depth
`ifndef AXIS_CFG_SVH
`define AXIS_CFG_SVH

// byte side of the loop
`define AXIS_NARROW_W 8

// word side of the loop, a whole multiple of the byte side
`define AXIS_WIDE_W 32

// one-bit sideband carried next to the data
`define AXIS_USER_W 1

// words held by the buffer between the two converters
`define AXIS_FIFO_DEPTH 4

// narrow lanes per wide word
`define AXIS_SEG_COUNT (`AXIS_WIDE_W / `AXIS_NARROW_W)

`endif

// ==== axis_pkg.sv ====
// stream types package: payload, keep, sideband and lane index types of the width loop
`include "axis_cfg.svh"

package axis_pkg;

    // bits needed to address one narrow lane inside a wide word
    localparam int SEG_IDX_W = $clog2(`AXIS_SEG_COUNT);

    // one byte beat on the narrow side
    typedef logic [`AXIS_NARROW_W-1:0] narrow_data_t;

    // one word on the wide side, lane 0 in the low bits
    typedef logic [`AXIS_WIDE_W-1:0] wide_data_t;

    // one keep bit per narrow lane
    // kept lanes always start at lane 0 and are contiguous
    typedef logic [`AXIS_SEG_COUNT-1:0] wide_keep_t;

    // sideband
    typedef logic [`AXIS_USER_W-1:0] user_t;

    // lane index used while packing
    typedef logic [SEG_IDX_W-1:0] seg_idx_t;

    // highest lane, a word closes when this lane fills
    localparam seg_idx_t LAST_SEG = seg_idx_t'(`AXIS_SEG_COUNT - 1);

endpackage

// ==== axis_upsizer.sv ====
// stream upsizer: packs narrow byte beats into wide words with per-lane keep
`timescale 1ns/1ps
`include "axis_cfg.svh"

module axis_upsizer (
    input  logic                   clk,
    input  logic                   rstn,

    // narrow input
    input  axis_pkg::narrow_data_t s_tdata,
    input  logic                   s_tvalid,
    output logic                   s_tready,
    input  logic                   s_tlast,
    input  axis_pkg::user_t        s_tuser,

    // wide output
    output axis_pkg::wide_data_t   m_tdata,
    output axis_pkg::wide_keep_t   m_tkeep,
    output logic                   m_tvalid,
    input  logic                   m_tready,
    output logic                   m_tlast,
    output axis_pkg::user_t        m_tuser
);

    import axis_pkg::*;

    // skid register for one byte taken while the word register is stalled
    narrow_data_t skid_data;
    logic         skid_valid;
    logic         skid_last;
    user_t        skid_user;

    // word being assembled, then presented
    wide_data_t   word_data;
    wide_keep_t   word_keep;
    logic         word_valid;
    logic         word_last;
    user_t        word_user;

    seg_idx_t     seg;

    logic         word_free;
    logic         in_avail;
    narrow_data_t in_data;
    logic         in_last;
    user_t        in_user;
    logic         in_close;

    assign s_tready = !skid_valid;

    assign m_tdata  = word_data;
    assign m_tkeep  = word_keep;
    assign m_tvalid = word_valid;
    assign m_tlast  = word_last;
    assign m_tuser  = word_user;

    // the word register can take a byte when idle or when its word leaves now
    assign word_free = !word_valid || m_tready;

    // skid byte is older, so it always goes first
    assign in_avail = skid_valid || s_tvalid;
    assign in_data  = skid_valid ? skid_data : s_tdata;
    assign in_last  = skid_valid ? skid_last : s_tlast;
    assign in_user  = skid_valid ? skid_user : s_tuser;

    // word closes on the top lane or at end of packet
    assign in_close = in_last || (seg == LAST_SEG);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            seg        <= '0;
            skid_valid <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            if (m_tready) begin
                word_valid <= 1'b0;
            end

            if (word_free) begin
                if (skid_valid) begin
                    skid_valid <= 1'b0;
                end
                if (in_avail) begin
                    if (in_close) begin
                        seg        <= '0;
                        word_valid <= 1'b1;
                    end else begin
                        seg <= seg + 1'b1;
                    end
                end
            end else if (s_tvalid && s_tready) begin
                skid_valid <= 1'b1;
            end
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (word_free && in_avail) begin
            word_data[seg*`AXIS_NARROW_W +: `AXIS_NARROW_W] <= in_data;
            // lane 0 starts a new word, so stale keep bits are dropped there
            if (seg == '0) begin
                word_keep <= wide_keep_t'(1);
            end else begin
                word_keep[seg] <= 1'b1;
            end
            word_last <= in_last;
            word_user <= in_user;
        end

        if (!word_free && s_tvalid && s_tready) begin
            skid_data <= s_tdata;
            skid_last <= s_tlast;
            skid_user <= s_tuser;
        end
    end

endmodule

// ==== axis_fifo.sv ====
// word FIFO: circular buffer of wide stream beats with a registered read port
`timescale 1ns/1ps
`include "axis_cfg.svh"

module axis_fifo (
    input  logic                 clk,
    input  logic                 rstn,

    // write side
    input  axis_pkg::wide_data_t s_tdata,
    input  axis_pkg::wide_keep_t s_tkeep,
    input  logic                 s_tvalid,
    output logic                 s_tready,
    input  logic                 s_tlast,
    input  axis_pkg::user_t      s_tuser,

    // read side
    output axis_pkg::wide_data_t m_tdata,
    output axis_pkg::wide_keep_t m_tkeep,
    output logic                 m_tvalid,
    input  logic                 m_tready,
    output logic                 m_tlast,
    output axis_pkg::user_t      m_tuser
);

    import axis_pkg::*;

    localparam int DEPTH = `AXIS_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    wide_data_t       mem_data [DEPTH];
    wide_keep_t       mem_keep [DEPTH];
    logic             mem_last [DEPTH];
    user_t            mem_user [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // occupancy counts the output register too
    logic [CNT_W-1:0] count;

    logic             push;
    logic             pop;
    logic             out_load;
    logic             mem_empty;

    assign s_tready  = (count != CNT_W'(DEPTH));
    assign push      = s_tvalid && s_tready;
    assign pop       = m_tvalid && m_tready;
    assign out_load  = !m_tvalid || m_tready;
    assign mem_empty = (count == CNT_W'(m_tvalid));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            m_tvalid <= 1'b0;
        end else begin
            count <= count + CNT_W'(push) - CNT_W'(pop);
            if (out_load) begin
                if (!mem_empty) begin
                    rd_ptr   <= rd_ptr + 1'b1;
                    m_tvalid <= 1'b1;
                end else begin
                    // empty buffer, a new word goes straight to the output
                    m_tvalid <= push;
                end
            end
            if (push && !(out_load && mem_empty)) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push && !(out_load && mem_empty)) begin
            mem_data[wr_ptr] <= s_tdata;
            mem_keep[wr_ptr] <= s_tkeep;
            mem_last[wr_ptr] <= s_tlast;
            mem_user[wr_ptr] <= s_tuser;
        end
        if (out_load && !mem_empty) begin
            m_tdata <= mem_data[rd_ptr];
            m_tkeep <= mem_keep[rd_ptr];
            m_tlast <= mem_last[rd_ptr];
            m_tuser <= mem_user[rd_ptr];
        end else if (out_load && push) begin
            m_tdata <= s_tdata;
            m_tkeep <= s_tkeep;
            m_tlast <= s_tlast;
            m_tuser <= s_tuser;
        end
    end

endmodule

// ==== axis_downsizer.sv ====
// stream downsizer: unpacks wide words into byte beats up to the last kept lane
`timescale 1ns/1ps
`include "axis_cfg.svh"

module axis_downsizer (
    input  logic                   clk,
    input  logic                   rstn,

    // wide input
    input  axis_pkg::wide_data_t   s_tdata,
    input  axis_pkg::wide_keep_t   s_tkeep,
    input  logic                   s_tvalid,
    output logic                   s_tready,
    input  logic                   s_tlast,
    input  axis_pkg::user_t        s_tuser,

    // narrow output
    output axis_pkg::narrow_data_t m_tdata,
    output logic                   m_tvalid,
    input  logic                   m_tready,
    output logic                   m_tlast,
    output axis_pkg::user_t        m_tuser
);

    import axis_pkg::*;

    // shift buffer, lane 0 always holds the next byte to send
    wide_data_t   buf_data;
    wide_keep_t   buf_keep;
    logic         buf_valid;
    logic         buf_last;
    user_t        buf_user;

    logic         byte_free;
    logic         take_word;
    wide_keep_t   buf_keep_next;
    wide_keep_t   in_keep_next;

    assign s_tready = !buf_valid;
    assign take_word = s_tvalid && s_tready;

    // byte register is free when idle or when its byte leaves now
    assign byte_free = !m_tvalid || m_tready;

    assign buf_keep_next = buf_keep >> 1;
    assign in_keep_next  = s_tkeep >> 1;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            buf_valid <= 1'b0;
            m_tvalid  <= 1'b0;
        end else begin
            if (m_tready) begin
                m_tvalid <= 1'b0;
            end

            if (byte_free) begin
                if (buf_valid) begin
                    m_tvalid <= 1'b1;
                    // buffer drains when no kept lane remains above the one sent
                    if (buf_keep_next == '0) begin
                        buf_valid <= 1'b0;
                    end
                end else if (take_word) begin
                    m_tvalid  <= 1'b1;
                    buf_valid <= (in_keep_next != '0);
                end
            end else if (take_word) begin
                buf_valid <= 1'b1;
            end
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (byte_free) begin
            if (buf_valid) begin
                m_tdata  <= buf_data[`AXIS_NARROW_W-1:0];
                m_tuser  <= buf_user;
                m_tlast  <= buf_last && (buf_keep_next == '0);
                buf_data <= buf_data >> `AXIS_NARROW_W;
                buf_keep <= buf_keep_next;
            end else if (take_word) begin
                // first lane goes out directly, the rest waits in the buffer
                m_tdata  <= s_tdata[`AXIS_NARROW_W-1:0];
                m_tuser  <= s_tuser;
                m_tlast  <= s_tlast && (in_keep_next == '0);
                buf_data <= s_tdata >> `AXIS_NARROW_W;
                buf_keep <= in_keep_next;
                buf_last <= s_tlast;
                buf_user <= s_tuser;
            end
        end else if (take_word) begin
            // stalled output, hold the whole word
            buf_data <= s_tdata;
            buf_keep <= s_tkeep;
            buf_last <= s_tlast;
            buf_user <= s_tuser;
        end
    end

endmodule

// ==== axis_width_loop.sv ====
// width loop top: byte stream packed to words, buffered, then unpacked to bytes
`timescale 1ns/1ps
`include "axis_cfg.svh"

module axis_width_loop (
    input  logic                   clk,
    input  logic                   rstn,

    // byte stream in
    input  axis_pkg::narrow_data_t s_tdata,
    input  logic                   s_tvalid,
    output logic                   s_tready,
    input  logic                   s_tlast,
    input  axis_pkg::user_t        s_tuser,

    // byte stream out
    output axis_pkg::narrow_data_t m_tdata,
    output logic                   m_tvalid,
    input  logic                   m_tready,
    output logic                   m_tlast,
    output axis_pkg::user_t        m_tuser
);

    import axis_pkg::*;

    // upsizer to FIFO
    wide_data_t up_tdata;
    wide_keep_t up_tkeep;
    logic       up_tvalid;
    logic       up_tready;
    logic       up_tlast;
    user_t      up_tuser;

    // FIFO to downsizer
    wide_data_t fifo_tdata;
    wide_keep_t fifo_tkeep;
    logic       fifo_tvalid;
    logic       fifo_tready;
    logic       fifo_tlast;
    user_t      fifo_tuser;

    axis_upsizer i_upsizer (
        .clk      (clk),
        .rstn     (rstn),
        .s_tdata  (s_tdata),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tlast  (s_tlast),
        .s_tuser  (s_tuser),
        .m_tdata  (up_tdata),
        .m_tkeep  (up_tkeep),
        .m_tvalid (up_tvalid),
        .m_tready (up_tready),
        .m_tlast  (up_tlast),
        .m_tuser  (up_tuser)
    );

    axis_fifo i_fifo (
        .clk      (clk),
        .rstn     (rstn),
        .s_tdata  (up_tdata),
        .s_tkeep  (up_tkeep),
        .s_tvalid (up_tvalid),
        .s_tready (up_tready),
        .s_tlast  (up_tlast),
        .s_tuser  (up_tuser),
        .m_tdata  (fifo_tdata),
        .m_tkeep  (fifo_tkeep),
        .m_tvalid (fifo_tvalid),
        .m_tready (fifo_tready),
        .m_tlast  (fifo_tlast),
        .m_tuser  (fifo_tuser)
    );

    axis_downsizer i_downsizer (
        .clk      (clk),
        .rstn     (rstn),
        .s_tdata  (fifo_tdata),
        .s_tkeep  (fifo_tkeep),
        .s_tvalid (fifo_tvalid),
        .s_tready (fifo_tready),
        .s_tlast  (fifo_tlast),
        .s_tuser  (fifo_tuser),
        .m_tdata  (m_tdata),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tlast  (m_tlast),
        .m_tuser  (m_tuser)
    );

endmodule

// ==== tb_axis_width_loop.sv ====
// testbench for the stream width loop driving byte packets through the pack, buffer and unpack path
`timescale 1ns/1ps
`include "axis_cfg.svh"

module tb_axis_width_loop;

    import axis_pkg::*;

    localparam int SEG        = `AXIS_SEG_COUNT;
    localparam int WAIT_LIMIT = 2000;

    logic         clk;
    logic         rstn;
    narrow_data_t s_tdata;
    logic         s_tvalid;
    logic         s_tready;
    logic         s_tlast;
    user_t        s_tuser;
    narrow_data_t m_tdata;
    logic         m_tvalid;
    logic         m_tready = 1'b1;
    logic         m_tlast;
    user_t        m_tuser;

    string        cur_test;
    logic         rand_ready;
    logic         ready_level;

    // packet under construction and the bytes expected at the output
    narrow_data_t pkt_data[$];
    user_t        pkt_user[$];
    narrow_data_t exp_data[$];
    logic         exp_last[$];
    user_t        exp_user[$];

    // output payload seen while stalled
    logic         stalled = 1'b0;
    narrow_data_t held_data;
    logic         held_last;
    user_t        held_user;

    axis_width_loop i_dut (
        .clk      (clk),
        .rstn     (rstn),
        .s_tdata  (s_tdata),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tlast  (s_tlast),
        .s_tuser  (s_tuser),
        .m_tdata  (m_tdata),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tlast  (m_tlast),
        .m_tuser  (m_tuser)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // output side ready is either held or random
    always @(negedge clk) begin
        m_tready = rand_ready ? ($urandom_range(0, 3) != 0) : ready_level;
    end

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s %s expected %0h actual %0h", cur_test, what, expected, actual);
            stop_run();
        end
    endtask

    // output monitor comparing every transferred byte with the model queue
    always @(posedge clk) begin
        if (!rstn) begin
            stalled = 1'b0;
        end else begin
            if (stalled) begin
                check_value("held m_tvalid", 1, m_tvalid);
                check_value("held m_tdata", held_data, m_tdata);
                check_value("held m_tlast", held_last, m_tlast);
                check_value("held m_tuser", held_user, m_tuser);
            end
            if (m_tvalid && m_tready) begin
                if (exp_data.size() == 0) begin
                    $display("output byte %0h arrived in %s with no byte pending", m_tdata,
                             cur_test);
                    stop_run();
                end
                check_value("m_tdata", exp_data.pop_front(), m_tdata);
                check_value("m_tlast", exp_last.pop_front(), m_tlast);
                check_value("m_tuser", exp_user.pop_front(), m_tuser);
            end
            stalled   = m_tvalid && !m_tready;
            held_data = m_tdata;
            held_last = m_tlast;
            held_user = m_tuser;
        end
    end

    task automatic fill_packet(input int n, input narrow_data_t first);
        int i;
        pkt_data.delete();
        pkt_user.delete();
        for (i = 0; i < n; i++) begin
            pkt_data.push_back(first + narrow_data_t'(i));
            pkt_user.push_back('0);
        end
    endtask

    task automatic drive_beat(input narrow_data_t d, input logic l, input user_t u,
                              input bit gaps);
        int idle;
        int t;
        if (gaps) begin
            idle = $urandom_range(0, 2);
            repeat (idle) begin
                @(negedge clk);
                s_tvalid = 1'b0;
            end
        end
        @(negedge clk);
        s_tvalid = 1'b1;
        s_tdata  = d;
        s_tlast  = l;
        s_tuser  = u;
        t = 0;
        // s_tready only moves on the rising edge
        while (!s_tready) begin
            if (t >= WAIT_LIMIT) begin
                $display("s_tready stayed low too long in %s", cur_test);
                stop_run();
            end
            t++;
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic send_packet(input bit gaps);
        int n;
        int i;
        int close_idx;
        n = pkt_data.size();
        // each byte takes the tuser of the byte that closes its word
        for (i = 0; i < n; i++) begin
            close_idx = (i / SEG) * SEG + SEG - 1;
            if (close_idx > n - 1) begin
                close_idx = n - 1;
            end
            exp_data.push_back(pkt_data[i]);
            exp_last.push_back(i == n - 1);
            exp_user.push_back(pkt_user[close_idx]);
        end
        for (i = 0; i < n; i++) begin
            drive_beat(pkt_data[i], i == n - 1, pkt_user[i], gaps);
        end
        @(negedge clk);
        s_tvalid = 1'b0;
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (exp_data.size() != 0) begin
            if (t >= WAIT_LIMIT) begin
                $display("%0d output bytes never arrived in %s", exp_data.size(), cur_test);
                stop_run();
            end
            t++;
            @(posedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic eight_byte_packet();
        cur_test = "basic_8_bytes";
        fill_packet(8, 8'h10);
        send_packet(0);
        wait_drain();
    endtask

    task automatic short_packets();
        cur_test = "short_packets";
        fill_packet(1, 8'h21);
        send_packet(0);
        fill_packet(2, 8'h31);
        send_packet(0);
        fill_packet(3, 8'h41);
        send_packet(0);
        fill_packet(5, 8'h51);
        send_packet(0);
        wait_drain();
    endtask

    task automatic random_backpressure();
        int p;
        int n;
        int i;
        cur_test   = "random_backpressure";
        rand_ready = 1'b1;
        for (p = 0; p < 20; p++) begin
            n = $urandom_range(1, 12);
            pkt_data.delete();
            pkt_user.delete();
            for (i = 0; i < n; i++) begin
                pkt_data.push_back(narrow_data_t'($urandom_range(0, 255)));
                pkt_user.push_back(user_t'($urandom_range(0, 1)));
            end
            send_packet(1);
        end
        wait_drain();
        rand_ready = 1'b0;
    endtask

    task automatic tuser_groups();
        cur_test = "tuser_groups";
        fill_packet(7, 8'h60);
        // mixed tuser inside each group of four
        pkt_user = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
        send_packet(0);
        fill_packet(6, 8'h70);
        pkt_user = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
        send_packet(0);
        wait_drain();
    endtask

    task automatic reset_mid_packet();
        int i;
        cur_test    = "mid_packet_reset";
        ready_level = 1'b0;
        fill_packet(25, 8'hA0);
        // no tlast, enough bytes to fill every stage up to the input skid register
        for (i = 0; i < 25; i++) begin
            drive_beat(pkt_data[i], 1'b0, '0, 0);
        end
        @(negedge clk);
        s_tvalid = 1'b0;
        repeat (6) @(negedge clk);
        check_value("s_tready before reset", 0, s_tready);
        rstn = 1'b0;
        repeat (4) @(negedge clk);
        check_value("m_tvalid after reset", 0, m_tvalid);
        check_value("s_tready after reset", 1, s_tready);
        check_value("fifo count after reset", 0, i_dut.i_fifo.count);
        rstn        = 1'b1;
        ready_level = 1'b1;
        fill_packet(8, 8'hC0);
        send_packet(0);
        wait_drain();
    endtask

    initial begin
        void'($urandom(18));
        rstn        = 1'b0;
        s_tvalid    = 1'b0;
        s_tdata     = '0;
        s_tlast     = 1'b0;
        s_tuser     = '0;
        rand_ready  = 1'b0;
        ready_level = 1'b1;
        cur_test    = "reset";
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        repeat (2) @(negedge clk);

        eight_byte_packet();
        short_packets();
        random_backpressure();
        tuser_groups();
        reset_mid_packet();

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
axis_pkg.sv
axis_upsizer.sv
axis_fifo.sv
axis_downsizer.sv
axis_width_loop.sv
tb_axis_width_loop.sv

// ==== Bender.yml ====
package:
  name: axis_width_loop

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - axis_pkg.sv
      - axis_upsizer.sv
      - axis_fifo.sv
      - axis_downsizer.sv
      - axis_width_loop.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_axis_width_loop.sv
